// File: test/stim_frame.txt
# W addr data writes data, R addr data reads and expects data, all hex
# F depth stall runs a frame, depth 1 expects depth bursts, stall 1 adds back-pressure
R 000D 495249
R 000A FFFFFF
R 0006 000000
R 0008 000000
W 0000 012340
W 0001 000007
W 0009 3F2A15
W 000A 123456
R 0000 012340
R 0001 000007
R 0009 3F2A15
R 000A 123456
R 0004 000000
F 0 0
R 0008 000001
R 0006 000000
W 0008 000001
R 0008 000000
F 0 1
W 0008 000001
W 0002 400000
W 0003 000007
R 0002 400000
R 0003 000007
F 1 0
R 0008 000001
W 0008 000001
F 1 1
R 0006 000000

// File: files.f
+incdir+include
verilog/raster_pkg.sv
verilog/tile_flush_if.sv
verilog/host_regs.sv
verilog/tile_walker.sv
verilog/flush_dma.sv
verilog/raster_core.sv
test/tb_raster_core.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat files.f)) include/raster_cfg.svh

all: run

obj_dir/Vtb_raster_core: files.f $(SRCS)
	verilator --binary --timing -j 0 -f files.f --top-module tb_raster_core

run: obj_dir/Vtb_raster_core
	./obj_dir/Vtb_raster_core

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: test/tb_raster_core.sv
`timescale 1ns/10ps
`include "raster_cfg.svh"

module tb_raster_core
    import raster_pkg::*;
();

    // Frames x tiles x bursts x cycles per burst
    localparam int TIMEOUT_CYCLES = 8 * 8 * 2 * 400;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        cmd_write;
    cmd_addr_t   cmd_addr;
    cmd_data_t   cmd_wdata;
    cmd_data_t   cmd_rdata;
    logic        awvalid;
    logic        awready;
    axi_addr_t   awaddr;
    logic [7:0]  awlen;
    logic        wvalid;
    logic        wready;
    axi_data_t   wdata;
    logic        wlast;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        frame_done_irq;

    // Register shadows
    axi_addr_t   rt_shadow;
    axi_addr_t   ds_shadow;
    pixel_t      color_shadow;
    pixel_t      depth_shadow;

    // Memory side records
    axi_addr_t   aw_q[$];
    axi_data_t   beat_q[$];
    logic        bp_on;         // Random back-pressure
    logic        b_pending;
    int          beat_in_burst;
    int          b_count;
    int          b_at_irq;
    int          irq_count;
    int          cycle_count;

    raster_core UUT (.*);

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Failure reporting and compares
    // ------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("TEST FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic stop_on_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        abort_run("Stopped at the first mismatch");
    endtask

    task automatic check_rdata(input cmd_data_t got, input cmd_data_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(input axi_addr_t got, input axi_addr_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_beat(input axi_data_t got, input axi_data_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            stop_on_mismatch($sformatf("%s counted %0d, expected %0d", what, got, exp));
    endtask

    // ------------------------------------------------------------
    // Command port
    // ------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input cmd_addr_t addr, input cmd_data_t data);
        cmd_valid = 1'b1;
        cmd_write = 1'b1;
        cmd_addr  = addr;
        cmd_wdata = data;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        case (addr)
            `REG_RT_BASE_LO:  rt_shadow[23:0]  = data;
            `REG_RT_BASE_HI:  rt_shadow[47:24] = data;
            `REG_DS_BASE_LO:  ds_shadow[23:0]  = data;
            `REG_DS_BASE_HI:  ds_shadow[47:24] = data;
            `REG_CLEAR_COLOR: color_shadow     = data;
            `REG_CLEAR_DEPTH: depth_shadow     = data;
            default: ;
        endcase
    endtask

    task automatic read_reg(input cmd_addr_t addr, input cmd_data_t exp);
        cmd_valid = 1'b1;
        cmd_write = 1'b0;
        cmd_addr  = addr;
        @(posedge clk);
        check_flag(cmd_ready, 1'b1, "cmd_ready");
        #1;
        cmd_valid = 1'b0;
        check_rdata(cmd_rdata, exp, $sformatf("register %h", addr));
    endtask

    // Tile origin is 16 lines down per row and 16 pixels of 3 bytes per column
    function automatic axi_addr_t tile_offset(input int col, input int row);
        return axi_addr_t'(row * `TILE_SIZE * `LINE_STRIDE + col * `TILE_SIZE * (`PIX_BITS / 8));
    endfunction

    task automatic check_burst(input int idx, input axi_addr_t addr, input pixel_t pix,
                               input string kind);
        check_addr(aw_q[idx], addr, $sformatf("%s burst %0d address", kind, idx));
        for (int k = 0; k < `TILE_BEATS; k++)
            check_beat(beat_q[idx * `TILE_BEATS + k], {8{pix}},
                       $sformatf("%s burst %0d beat %0d", kind, idx, k));
    endtask

    task automatic run_frame(input int depth, input int stall);
        int bursts;
        int irq_before;
        int b_before;
        int idx;
        bursts     = (depth != 0) ? 16 : 8;
        irq_before = irq_count;
        b_before   = b_count;
        idx        = 0;
        bp_on      = (stall != 0);
        aw_q.delete();
        beat_q.delete();
        write_reg(`REG_CONTROL, 24'h000001);
        wait_cycles(3);
        read_reg(`REG_STATUS, 24'h000002);   // Busy with the kick already taken
        while (irq_count == irq_before)
            @(posedge clk);
        wait_cycles(8);
        check_count(irq_count - irq_before, 1, "frame_done_irq pulses");
        check_count(b_at_irq - b_before, bursts, "B responses before frame_done_irq");
        check_count(aw_q.size(), bursts, "bursts");
        check_count(beat_q.size(), bursts * `TILE_BEATS, "beats");
        for (int row = 0; row < `TILE_ROWS; row++) begin
            for (int col = 0; col < `TILE_COLS; col++) begin
                check_burst(idx, rt_shadow + tile_offset(col, row), color_shadow, "color");
                idx++;
                if (depth != 0) begin
                    check_burst(idx, ds_shadow + tile_offset(col, row), depth_shadow, "depth");
                    idx++;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // AXI memory responder
    // ------------------------------------------------------------
    always @(posedge clk) begin : responder
        logic b_done;
        b_done = 1'b0;
        if (rst_n) begin
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
                check_count(int'(awlen), `TILE_BEATS - 1, "awlen");
                beat_in_burst = 0;
            end
            if (wvalid && wready) begin
                beat_q.push_back(wdata);
                check_flag(wlast, (beat_in_burst == `TILE_BEATS - 1), "wlast");
                if (wlast)
                    b_pending = 1'b1;
                beat_in_burst++;
            end
            if (bvalid && bready) begin
                b_count++;
                b_done = 1'b1;
            end
            if (frame_done_irq) begin
                irq_count++;
                b_at_irq = b_count;
            end
        end
        #1;
        awready = !bp_on || (($urandom & 32'd3) != 32'd0);
        wready  = !bp_on || (($urandom & 32'd3) != 32'd0);
        if (b_done) begin
            bvalid = 1'b0;
        end else if (b_pending && !bvalid && (!bp_on || (($urandom & 32'd1) != 32'd0))) begin
            bvalid    = 1'b1;   // Held until bready
            b_pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout, run did not end within %0d cycles", TIMEOUT_CYCLES));
    end

    // ------------------------------------------------------------
    // Stim file player
    // ------------------------------------------------------------
    initial begin
        int            fd;
        int            code;
        logic [63:0]   op;
        logic [1023:0] line_buf;
        cmd_addr_t     addr;
        cmd_data_t     data;
        int            depth;
        int            stall;
        logic          done_reading;

        clk           = 1'b0;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_write     = 1'b0;
        cmd_addr      = '0;
        cmd_wdata     = '0;
        awready       = 1'b0;
        wready        = 1'b0;
        bvalid        = 1'b0;
        bresp         = 2'b00;
        bp_on         = 1'b0;
        b_pending     = 1'b0;
        beat_in_burst = 0;
        b_count       = 0;
        b_at_irq      = 0;
        irq_count     = 0;
        cycle_count   = 0;
        rt_shadow     = '0;
        ds_shadow     = '0;
        color_shadow  = '0;
        depth_shadow  = '1;
        void'($urandom(32'h40e64ebf));

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag(awvalid | wvalid | bready | frame_done_irq, 1'b0, "outputs after reset");

        fd = $fopen("test/stim_frame.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open test/stim_frame.txt");
        end else begin
            done_reading = 1'b0;
            while (!done_reading) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done_reading = 1'b1;
                end else if (op[7:0] == "#") begin
                    code = $fgets(line_buf, fd);
                end else if (op[7:0] == "W") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    write_reg(addr, data);
                end else if (op[7:0] == "R") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    read_reg(addr, data);
                end else if (op[7:0] == "F") begin
                    code = $fscanf(fd, "%d %d", depth, stall);
                    run_frame(depth, stall);
                end else begin
                    abort_run("Unknown command in test/stim_frame.txt");
                end
            end
            $fclose(fd);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: verilog/raster_core.sv
`timescale 1ns/10ps

module raster_core
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Host command port
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       cmd_write,
    input  cmd_addr_t  cmd_addr,
    input  cmd_data_t  cmd_wdata,
    output cmd_data_t  cmd_rdata,

    // AXI4 write to external memory
    output logic       awvalid,
    input  logic       awready,
    output axi_addr_t  awaddr,
    output logic [7:0] awlen,
    output logic       wvalid,
    input  logic       wready,
    output axi_data_t  wdata,
    output logic       wlast,
    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp,

    output logic       frame_done_irq
);

    logic      kick;
    logic      kick_taken;
    logic      busy;
    axi_addr_t rt_base;
    axi_addr_t ds_base;
    pixel_t    clear_color;
    pixel_t    clear_depth;

    tile_flush_if flush_bus ();

    host_regs u_host_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_ready   (cmd_ready),
        .cmd_rdata   (cmd_rdata),
        .kick_taken  (kick_taken),
        .busy        (busy),
        .frame_done  (frame_done_irq),
        .kick        (kick),
        .rt_base     (rt_base),
        .ds_base     (ds_base),
        .clear_color (clear_color),
        .clear_depth (clear_depth)
    );

    tile_walker u_tile_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .kick        (kick),
        .kick_taken  (kick_taken),
        .busy        (busy),
        .frame_done  (frame_done_irq),
        .rt_base     (rt_base),
        .clear_color (clear_color),
        .clear_depth (clear_depth),
        .flush       (flush_bus.walker)
    );

    flush_dma u_flush_dma (
        .clk     (clk),
        .rst_n   (rst_n),
        .rt_base (rt_base),
        .ds_base (ds_base),
        .flush   (flush_bus.dma),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp)
    );

endmodule

// File: verilog/flush_dma.sv
`timescale 1ns/10ps
`include "raster_cfg.svh"

module flush_dma
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  axi_addr_t  rt_base,
    input  axi_addr_t  ds_base,
    tile_flush_if.dma  flush,

    output logic       awvalid,
    input  logic       awready,
    output axi_addr_t  awaddr,
    output logic [7:0] awlen,

    output logic       wvalid,
    input  logic       wready,
    output axi_data_t  wdata,
    output logic       wlast,

    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp    // Not checked
);

    dma_state_t state;
    beat_idx_t  beat_idx;
    logic [2:0] sub_idx;        // Pixel within the beat being gathered
    logic       do_depth;
    logic       bank;
    axi_addr_t  depth_addr;
    pixel_t     rd_pixel;
    logic       last_beat;
    logic       accept;

    assign flush.req_ready = (state == DMA_IDLE);
    assign flush.rd_bank   = bank;
    assign flush.rd_pix    = {beat_idx[4:0], sub_idx};
    assign accept          = (state == DMA_IDLE) && flush.req_valid;
    assign rd_pixel        = (state == DMA_W_DEPTH) ? flush.rd_depth : flush.rd_color;
    assign last_beat       = (beat_idx == beat_idx_t'(`TILE_BEATS - 1));
    assign awlen           = 8'(`TILE_BEATS - 1);

    // ----------------------------------------------------------
    // Burst payload
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            bank       <= flush.bank;
            awaddr     <= flush.color_addr;
            depth_addr <= ds_base + (flush.color_addr - rt_base);
        end else if (state == DMA_B_COLOR && bvalid) begin
            awaddr <= depth_addr;
        end

        // Shift in from the top so the lowest pixel ends in the low bits
        if ((state == DMA_W_COLOR || state == DMA_W_DEPTH) && !wvalid)
            wdata <= {rd_pixel, wdata[`AXI_DATA_BITS-1:`PIX_BITS]};
    end

    // ----------------------------------------------------------
    // Burst FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DMA_IDLE;
            beat_idx <= '0;
            sub_idx  <= '0;
            do_depth <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            wlast    <= 1'b0;
            bready   <= 1'b0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (flush.req_valid) begin
                        do_depth <= |ds_base;
                        awvalid  <= 1'b1;
                        state    <= DMA_AW_COLOR;
                    end
                end
                DMA_AW_COLOR, DMA_AW_DEPTH: begin
                    if (awready) begin
                        awvalid  <= 1'b0;
                        beat_idx <= '0;
                        sub_idx  <= '0;
                        state    <= (state == DMA_AW_COLOR) ? DMA_W_COLOR : DMA_W_DEPTH;
                    end
                end
                DMA_W_COLOR, DMA_W_DEPTH: begin
                    if (!wvalid) begin
                        sub_idx <= sub_idx + 3'd1;
                        if (sub_idx == 3'd7) begin   // Beat complete
                            wvalid <= 1'b1;
                            wlast  <= last_beat;
                        end
                    end else if (wready) begin
                        wvalid   <= 1'b0;
                        wlast    <= 1'b0;
                        beat_idx <= beat_idx + 6'd1;
                        if (last_beat) begin
                            bready <= 1'b1;
                            state  <= (state == DMA_W_COLOR) ? DMA_B_COLOR : DMA_B_DEPTH;
                        end
                    end
                end
                DMA_B_COLOR: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        if (do_depth) begin
                            awvalid <= 1'b1;
                            state   <= DMA_AW_DEPTH;
                        end else begin
                            state <= DMA_IDLE;
                        end
                    end
                end
                DMA_B_DEPTH: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state  <= DMA_IDLE;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/tile_walker.sv
`timescale 1ns/10ps
`include "raster_cfg.svh"

module tile_walker
    import raster_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         kick,
    output logic         kick_taken,
    output logic         busy,
    output logic         frame_done,
    input  axi_addr_t    rt_base,
    input  pixel_t       clear_color,
    input  pixel_t       clear_depth,
    tile_flush_if.walker flush
);

    // Double-buffered tile store
    pixel_t      color_mem [2][`TILE_PIXELS];
    pixel_t      depth_mem [2][`TILE_PIXELS];

    walk_state_t state;
    tile_idx_t   tile_col;
    tile_idx_t   tile_row;
    pix_idx_t    cursor;
    logic        wr_bank;
    logic        last_tile;
    axi_addr_t   tile_offset;

    assign busy       = (state != WALK_IDLE);
    assign kick_taken = (state == WALK_IDLE) && kick;
    assign frame_done = (state == WALK_DONE);   // Single cycle
    assign last_tile  = (tile_col == tile_idx_t'(`TILE_COLS - 1)) &&
                        (tile_row == tile_idx_t'(`TILE_ROWS - 1));

    // Tile origin inside the render target
    assign tile_offset = axi_addr_t'(tile_row) * axi_addr_t'(`TILE_SIZE * `LINE_STRIDE) +
                         axi_addr_t'(tile_col) * axi_addr_t'(`TILE_SIZE * `PIX_BITS / 8);

    always_ff @(posedge clk) begin
        if (state == WALK_CLEAR) begin
            color_mem[wr_bank][cursor] <= clear_color;
            depth_mem[wr_bank][cursor] <= clear_depth;
        end
    end

    assign flush.rd_color = color_mem[flush.rd_bank][flush.rd_pix];
    assign flush.rd_depth = depth_mem[flush.rd_bank][flush.rd_pix];

    // Request payload loaded as the request is raised
    always_ff @(posedge clk) begin
        if (state == WALK_QUEUE) begin
            flush.color_addr <= rt_base + tile_offset;
            flush.bank       <= wr_bank;
        end
    end

    // ----------------------------------------------------------
    // Walk FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= WALK_IDLE;
            tile_col        <= '0;
            tile_row        <= '0;
            cursor          <= '0;
            wr_bank         <= 1'b0;
            flush.req_valid <= 1'b0;
        end else begin
            case (state)
                WALK_IDLE: begin
                    if (kick) begin
                        tile_col <= '0;
                        tile_row <= '0;
                        cursor   <= '0;
                        wr_bank  <= 1'b0;
                        state    <= WALK_CLEAR;
                    end
                end
                WALK_CLEAR: begin
                    cursor <= cursor + 8'd1;   // Wraps to 0 after the last pixel
                    if (cursor == pix_idx_t'(`TILE_PIXELS - 1))
                        state <= WALK_QUEUE;
                end
                WALK_QUEUE: begin
                    flush.req_valid <= 1'b1;
                    wr_bank         <= ~wr_bank;   // Next tile goes to the other bank
                    state           <= WALK_WAIT_ACCEPT;
                end
                WALK_WAIT_ACCEPT: begin
                    if (flush.req_ready) begin
                        flush.req_valid <= 1'b0;
                        state           <= WALK_ADVANCE;
                    end
                end
                WALK_ADVANCE: begin
                    if (last_tile) begin
                        state <= WALK_DRAIN;
                    end else begin
                        if (tile_col == tile_idx_t'(`TILE_COLS - 1)) begin
                            tile_col <= '0;
                            tile_row <= tile_row + 6'd1;
                        end else begin
                            tile_col <= tile_col + 6'd1;
                        end
                        state <= WALK_CLEAR;
                    end
                end
                WALK_DRAIN: begin
                    if (flush.req_ready)   // DMA back to idle
                        state <= WALK_DONE;
                end
                WALK_DONE: state <= WALK_IDLE;
                default:   state <= WALK_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/host_regs.sv
`timescale 1ns/10ps
`include "raster_cfg.svh"

module host_regs
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cmd_valid,
    input  logic      cmd_write,
    input  cmd_addr_t cmd_addr,
    input  cmd_data_t cmd_wdata,
    output logic      cmd_ready,
    output cmd_data_t cmd_rdata,

    input  logic      kick_taken,
    input  logic      busy,
    input  logic      frame_done,
    output logic      kick,
    output axi_addr_t rt_base,
    output axi_addr_t ds_base,
    output pixel_t    clear_color,
    output pixel_t    clear_depth
);

    cmd_data_t control_reg;
    logic      kick_pending;
    logic      status_kick;
    logic      status_busy;
    logic      irq_frame_done;   // Sticky, W1C
    logic      wr_en;
    logic      rd_en;

    assign cmd_ready = 1'b1;
    assign wr_en     = cmd_valid & cmd_write;
    assign rd_en     = cmd_valid & ~cmd_write;
    assign kick      = kick_pending;

    // ----------------------------------------------------------
    // Register writes, kick latch, interrupt status
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_base        <= '0;
            ds_base        <= '0;
            clear_color    <= '0;
            clear_depth    <= '1;
            control_reg    <= '0;
            kick_pending   <= 1'b0;
            status_kick    <= 1'b0;
            status_busy    <= 1'b0;
            irq_frame_done <= 1'b0;
        end else begin
            if (kick_taken)
                kick_pending <= 1'b0;

            if (wr_en) begin
                case (cmd_addr)
                    `REG_RT_BASE_LO:  rt_base[23:0]  <= cmd_wdata;
                    `REG_RT_BASE_HI:  rt_base[47:24] <= cmd_wdata;
                    `REG_DS_BASE_LO:  ds_base[23:0]  <= cmd_wdata;
                    `REG_DS_BASE_HI:  ds_base[47:24] <= cmd_wdata;
                    `REG_CLEAR_COLOR: clear_color    <= cmd_wdata;
                    `REG_CLEAR_DEPTH: clear_depth    <= cmd_wdata;
                    `REG_IRQ_STATUS:  irq_frame_done <= irq_frame_done & ~cmd_wdata[0];
                    `REG_CONTROL: begin
                        control_reg <= cmd_wdata;
                        if (cmd_wdata[0])
                            kick_pending <= 1'b1;   // Held until the walker takes it
                    end
                    default: ;
                endcase
            end

            // New frame completion wins over a clear in the same cycle
            if (frame_done)
                irq_frame_done <= 1'b1;

            status_kick <= kick_pending;
            status_busy <= busy;
        end
    end

    // Registered read mux
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_rdata <= '0;
        end else if (rd_en) begin
            case (cmd_addr)
                `REG_RT_BASE_LO:  cmd_rdata <= rt_base[23:0];
                `REG_RT_BASE_HI:  cmd_rdata <= rt_base[47:24];
                `REG_DS_BASE_LO:  cmd_rdata <= ds_base[23:0];
                `REG_DS_BASE_HI:  cmd_rdata <= ds_base[47:24];
                `REG_CONTROL:     cmd_rdata <= control_reg;
                `REG_STATUS:      cmd_rdata <= {22'd0, status_busy, status_kick};
                `REG_IRQ_STATUS:  cmd_rdata <= {23'd0, irq_frame_done};
                `REG_CLEAR_COLOR: cmd_rdata <= clear_color;
                `REG_CLEAR_DEPTH: cmd_rdata <= clear_depth;
                `REG_VERSION:     cmd_rdata <= `VERSION_VALUE;
                default:          cmd_rdata <= '0;
            endcase
        end
    end

endmodule

// File: verilog/tile_flush_if.sv
`timescale 1ns/10ps

interface tile_flush_if
    import raster_pkg::*;
();

    // Flush request
    logic      req_valid;
    logic      req_ready;
    axi_addr_t color_addr;
    logic      bank;

    // Tile store read port
    logic      rd_bank;
    pix_idx_t  rd_pix;
    pixel_t    rd_color;
    pixel_t    rd_depth;

    modport walker (
        output req_valid, color_addr, bank, rd_color, rd_depth,
        input  req_ready, rd_bank, rd_pix
    );

    modport dma (
        input  req_valid, color_addr, bank, rd_color, rd_depth,
        output req_ready, rd_bank, rd_pix
    );

endinterface

// File: verilog/raster_pkg.sv
package raster_pkg;

    typedef logic [15:0]  cmd_addr_t;
    typedef logic [23:0]  cmd_data_t;
    typedef logic [47:0]  axi_addr_t;   // Byte address
    typedef logic [191:0] axi_data_t;
    typedef logic [23:0]  pixel_t;      // RGBA6 or U0.24 depth
    typedef logic [5:0]   tile_idx_t;
    typedef logic [7:0]   pix_idx_t;
    typedef logic [5:0]   beat_idx_t;

    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_CLEAR,
        WALK_QUEUE,
        WALK_WAIT_ACCEPT,
        WALK_ADVANCE,
        WALK_DRAIN,
        WALK_DONE
    } walk_state_t;

    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_AW_COLOR,
        DMA_W_COLOR,
        DMA_B_COLOR,
        DMA_AW_DEPTH,
        DMA_W_DEPTH,
        DMA_B_DEPTH
    } dma_state_t;

endpackage

// File: include/raster_cfg.svh
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// Tile and render target geometry
`define TILE_SIZE        16
`define TILE_PIXELS      (`TILE_SIZE * `TILE_SIZE)
`define RENDER_WIDTH     64
`define RENDER_HEIGHT    32
`define TILE_COLS        (`RENDER_WIDTH / `TILE_SIZE)
`define TILE_ROWS        (`RENDER_HEIGHT / `TILE_SIZE)

// Memory bus
`define PIX_BITS         24
`define AXI_DATA_BITS    192
`define PIXELS_PER_BEAT  (`AXI_DATA_BITS / `PIX_BITS)
`define TILE_BEATS       (`TILE_PIXELS / `PIXELS_PER_BEAT)
`define LINE_STRIDE      (`RENDER_WIDTH * `PIX_BITS / 8)

// ----------------------------------------------------------
// Command register map
// ----------------------------------------------------------
`define REG_RT_BASE_LO   16'h0000
`define REG_RT_BASE_HI   16'h0001
`define REG_DS_BASE_LO   16'h0002
`define REG_DS_BASE_HI   16'h0003
`define REG_CONTROL      16'h0005
`define REG_STATUS       16'h0006
`define REG_IRQ_STATUS   16'h0008
`define REG_CLEAR_COLOR  16'h0009
`define REG_CLEAR_DEPTH  16'h000A
`define REG_VERSION      16'h000D

`define VERSION_VALUE    24'h495249

`endif
